/* logic/decodeExecute_cfg.svh */
`ifndef DECODE_EXECUTE_CFG_SVH
`define DECODE_EXECUTE_CFG_SVH

//////////////////////////////
// Data path
//////////////////////////////

`define DATA_W 32 // One machine word

//////////////////////////////
// Instruction fields
//////////////////////////////

`define REG_W 5 // Register index, 32 registers

`define SHAMT_W 5 // Shift amount field and rs-based shift count

`endif

/* logic/isaPkg.sv */
`include "decodeExecute_cfg.svh"

package isaPkg;

	//////////////////////////////
	// Instruction word views
	//////////////////////////////

	typedef struct packed
	{
		logic [5:0] op; // Major opcode
		logic [`REG_W-1:0] rs; // First source
		logic [`REG_W-1:0] rt; // Second source
		logic [`REG_W-1:0] rd; // Destination
		logic [`SHAMT_W-1:0] shamt; // Constant shift count
		logic [5:0] funct; // ALU function
	} rFormat;

	typedef struct packed
	{
		logic [5:0] op; // Major opcode
		logic [`REG_W-1:0] rs; // Base or source
		logic [`REG_W-1:0] rt; // Destination or store data
		logic [15:0] imm16; // Raw immediate
	} iFormat;

	// Same 32 bits, read as R or I layout
	typedef union packed
	{
		rFormat r;
		iFormat i;
	} instrWord;

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	localparam logic [5:0] OP_RTYPE = 6'b000000; // Funct selects operation
	localparam logic [5:0] OP_LB = 6'b100000;
	localparam logic [5:0] OP_LH = 6'b100001;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_LBU = 6'b100100; // Same as LB here
	localparam logic [5:0] OP_LHU = 6'b100101; // Same as LH here
	localparam logic [5:0] OP_LWU = 6'b100111; // Same as LW here
	localparam logic [5:0] OP_SB = 6'b101000;
	localparam logic [5:0] OP_SH = 6'b101001;
	localparam logic [5:0] OP_SW = 6'b101011;
	localparam logic [5:0] OP_ADDI = 6'b001000;
	localparam logic [5:0] OP_SLTI = 6'b001010;
	localparam logic [5:0] OP_ANDI = 6'b001100; // Zero-extended imm
	localparam logic [5:0] OP_ORI = 6'b001101; // Zero-extended imm
	localparam logic [5:0] OP_XORI = 6'b001110; // Zero-extended imm
	localparam logic [5:0] OP_LUI = 6'b001111;
	localparam logic [5:0] OP_END = 6'b111111; // Program end, no effect

	//////////////////////////////
	// R-type functs
	//////////////////////////////

	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_SRL = 6'b000010;
	localparam logic [5:0] FN_SRA = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_NOR = 6'b100111;
	localparam logic [5:0] FN_SLT = 6'b101010;

endpackage

/* logic/ctrlPkg.sv */
package ctrlPkg;

	//////////////////////////////
	// ALU operations
	//////////////////////////////

	localparam logic [3:0] ALU_ADD = 4'd0;
	localparam logic [3:0] ALU_SUB = 4'd1;
	localparam logic [3:0] ALU_AND = 4'd2;
	localparam logic [3:0] ALU_OR = 4'd3;
	localparam logic [3:0] ALU_XOR = 4'd4;
	localparam logic [3:0] ALU_NOR = 4'd5;
	localparam logic [3:0] ALU_SLL = 4'd6; // Shift ops act on operand A
	localparam logic [3:0] ALU_SRL = 4'd7;
	localparam logic [3:0] ALU_SRA = 4'd8;
	localparam logic [3:0] ALU_SLT = 4'd9; // Signed compare, 0 or 1

	//////////////////////////////
	// Operand source
	//////////////////////////////

	localparam logic [1:0] SRC_REG = 2'd0; // B from rt, variable shift from rs
	localparam logic [1:0] SRC_IMM = 2'd1; // B from extended immediate
	localparam logic [1:0] SRC_SHAMT = 2'd2; // Shift count from shamt field

	//////////////////////////////
	// Memory access sizes
	//////////////////////////////

	localparam logic [1:0] RD_WORD = 2'd0; // Also the idle value
	localparam logic [1:0] RD_BYTE = 2'd1;
	localparam logic [1:0] RD_HALF = 2'd2;

	localparam logic [1:0] WR_NONE = 2'd0;
	localparam logic [1:0] WR_BYTE = 2'd1;
	localparam logic [1:0] WR_HALF = 2'd2;
	localparam logic [1:0] WR_WORD = 2'd3;

endpackage

/* logic/controlUnit.sv */
module controlUnit
(
	input logic [5:0] op,
	input logic [5:0] funct,
	input logic start, // Holds every control quiet
	output logic [3:0] aluControl,
	output logic regWrite,
	output logic memToReg,
	output logic memWrite,
	output logic [1:0] aluSrc,
	output logic regDst, // 1 selects rd, 0 selects rt
	output logic [3:0] shift, // Fixed shift in nibbles, 0 when unused
	output logic [1:0] memRead,
	output logic [1:0] memWriteSize
);

	localparam logic [3:0] LUI_NIBBLES = 4'd4; // Sixteen bits

	always_comb
	begin
		// All quiet unless a known instruction is decoded
		aluControl = ctrlPkg::ALU_ADD;
		regWrite = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrc = ctrlPkg::SRC_REG;
		regDst = 1'b0;
		shift = 4'd0;
		memRead = ctrlPkg::RD_WORD;
		memWriteSize = ctrlPkg::WR_NONE;

		if (!start)
		begin
			case (op)
				//////////////////////////////
				// Register-register
				//////////////////////////////
				isaPkg::OP_RTYPE:
				begin
					regWrite = 1'b1;
					regDst = 1'b1; // Result goes to rd
					case (funct)
						isaPkg::FN_ADD: aluControl = ctrlPkg::ALU_ADD;
						isaPkg::FN_SUB: aluControl = ctrlPkg::ALU_SUB;
						isaPkg::FN_AND: aluControl = ctrlPkg::ALU_AND;
						isaPkg::FN_OR: aluControl = ctrlPkg::ALU_OR;
						isaPkg::FN_XOR: aluControl = ctrlPkg::ALU_XOR;
						isaPkg::FN_NOR: aluControl = ctrlPkg::ALU_NOR;
						isaPkg::FN_SLT: aluControl = ctrlPkg::ALU_SLT;
						isaPkg::FN_SLL:
						begin
							aluControl = ctrlPkg::ALU_SLL;
							aluSrc = ctrlPkg::SRC_SHAMT; // Count from bits 10:6
						end
						isaPkg::FN_SRL:
						begin
							aluControl = ctrlPkg::ALU_SRL;
							aluSrc = ctrlPkg::SRC_SHAMT;
						end
						isaPkg::FN_SRA:
						begin
							aluControl = ctrlPkg::ALU_SRA;
							aluSrc = ctrlPkg::SRC_SHAMT;
						end
						isaPkg::FN_SLLV: aluControl = ctrlPkg::ALU_SLL; // Count from rs
						isaPkg::FN_SRLV: aluControl = ctrlPkg::ALU_SRL;
						isaPkg::FN_SRAV: aluControl = ctrlPkg::ALU_SRA;
						default:
						begin
							regWrite = 1'b0; // Unknown funct, nothing happens
							regDst = 1'b0;
						end
					endcase
				end

				//////////////////////////////
				// Loads and stores
				//////////////////////////////
				isaPkg::OP_LB, isaPkg::OP_LBU:
				begin
					regWrite = 1'b1;
					memToReg = 1'b1;
					aluSrc = ctrlPkg::SRC_IMM; // Base plus offset
					memRead = ctrlPkg::RD_BYTE;
				end
				isaPkg::OP_LH, isaPkg::OP_LHU:
				begin
					regWrite = 1'b1;
					memToReg = 1'b1;
					aluSrc = ctrlPkg::SRC_IMM;
					memRead = ctrlPkg::RD_HALF;
				end
				isaPkg::OP_LW, isaPkg::OP_LWU:
				begin
					regWrite = 1'b1;
					memToReg = 1'b1;
					aluSrc = ctrlPkg::SRC_IMM;
					memRead = ctrlPkg::RD_WORD; // Full word
				end
				isaPkg::OP_SB:
				begin
					memWrite = 1'b1;
					aluSrc = ctrlPkg::SRC_IMM;
					memWriteSize = ctrlPkg::WR_BYTE; // One lane
				end
				isaPkg::OP_SH:
				begin
					memWrite = 1'b1;
					aluSrc = ctrlPkg::SRC_IMM;
					memWriteSize = ctrlPkg::WR_HALF; // Two lanes
				end
				isaPkg::OP_SW:
				begin
					memWrite = 1'b1;
					aluSrc = ctrlPkg::SRC_IMM;
					memWriteSize = ctrlPkg::WR_WORD; // All four lanes
				end

				//////////////////////////////
				// Immediate ALU
				//////////////////////////////
				isaPkg::OP_ADDI, isaPkg::OP_ANDI, isaPkg::OP_ORI,
				isaPkg::OP_XORI, isaPkg::OP_SLTI:
				begin
					regWrite = 1'b1;
					aluSrc = ctrlPkg::SRC_IMM;
					case (op)
						isaPkg::OP_ANDI: aluControl = ctrlPkg::ALU_AND;
						isaPkg::OP_ORI: aluControl = ctrlPkg::ALU_OR;
						isaPkg::OP_XORI: aluControl = ctrlPkg::ALU_XOR;
						isaPkg::OP_SLTI: aluControl = ctrlPkg::ALU_SLT;
						default: aluControl = ctrlPkg::ALU_ADD; // ADDI
					endcase
				end
				isaPkg::OP_LUI:
				begin
					regWrite = 1'b1;
					aluSrc = ctrlPkg::SRC_IMM;
					shift = LUI_NIBBLES; // Immediate into the upper half
					aluControl = ctrlPkg::ALU_SLL;
				end

				// OP_END and unknown opcodes keep the quiet defaults
				default:
				begin
					regWrite = 1'b0;
				end
			endcase
		end
	end

endmodule

/* logic/operandUnit.sv */
`include "decodeExecute_cfg.svh"

module operandUnit
(
	input isaPkg::instrWord instr,
	output logic [`REG_W-1:0] rtIndex,
	output logic [`REG_W-1:0] rdIndex,
	output logic [`SHAMT_W-1:0] shamt,
	output logic [`DATA_W-1:0] immExt
);

	logic zeroExtend; // Logical-immediate group
	logic [`DATA_W-17:0] immUpper; // Bits above imm16

	//////////////////////////////
	// Register fields
	//////////////////////////////

	assign rtIndex = instr.i.rt; // Same bits in both views
	assign rdIndex = instr.r.rd; // Only meaningful for R-type
	assign shamt = instr.r.shamt; // Bits 10:6

	//////////////////////////////
	// Immediate extension
	//////////////////////////////

	// ANDI, ORI and XORI take the raw bits, all else sign-extends
	always_comb
	begin
		case (instr.i.op)
			isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI: zeroExtend = 1'b1;
			default: zeroExtend = 1'b0;
		endcase
	end

	assign immUpper = zeroExtend ? '0 : {(`DATA_W-16){instr.i.imm16[15]}};

	assign immExt = {immUpper, instr.i.imm16};

endmodule

/* logic/aluCore.sv */
`include "decodeExecute_cfg.svh"

module aluCore
(
	input logic [3:0] aluControl,
	input logic [`DATA_W-1:0] srcA, // Also the value being shifted
	input logic [`DATA_W-1:0] srcB,
	input logic [`SHAMT_W-1:0] shiftAmount,
	output logic [`DATA_W-1:0] result
);

	logic lessThan; // Signed A below B

	assign lessThan = $signed(srcA) < $signed(srcB);

	//////////////////////////////
	// Operation select
	//////////////////////////////

	always_comb
	begin
		case (aluControl)
			ctrlPkg::ALU_ADD:
				result = srcA + srcB; // Also address generation
			ctrlPkg::ALU_SUB:
				result = srcA - srcB;
			ctrlPkg::ALU_AND:
				result = srcA & srcB;
			ctrlPkg::ALU_OR:
				result = srcA | srcB;
			ctrlPkg::ALU_XOR:
				result = srcA ^ srcB;
			ctrlPkg::ALU_NOR:
				result = ~(srcA | srcB);
			ctrlPkg::ALU_SLL:
				result = srcA << shiftAmount;
			ctrlPkg::ALU_SRL:
				result = srcA >> shiftAmount; // Zero fill
			ctrlPkg::ALU_SRA:
				result = $signed(srcA) >>> shiftAmount; // Sign fill
			ctrlPkg::ALU_SLT:
				result = {{(`DATA_W-1){1'b0}}, lessThan};
			default:
				result = '0; // Unused codes
		endcase
	end

endmodule

/* logic/executeStage.sv */
`include "decodeExecute_cfg.svh"

module executeStage
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic [`DATA_W-1:0] rsData,
	input logic [`DATA_W-1:0] rtData,
	input logic [3:0] aluControl,
	input logic regWrite,
	input logic memToReg,
	input logic memWrite,
	input logic [1:0] aluSrc,
	input logic regDst,
	input logic [3:0] shift, // Nibble count, nonzero only for LUI
	input logic [1:0] memRead,
	input logic [1:0] memWriteSize,
	input logic [`REG_W-1:0] rtIndex,
	input logic [`REG_W-1:0] rdIndex,
	input logic [`SHAMT_W-1:0] shamt,
	input logic [`DATA_W-1:0] immExt,
	output logic resultValid, // One pulse per instruction
	output logic [`DATA_W-1:0] aluResult,
	output logic [`REG_W-1:0] writeReg,
	output logic regWriteE,
	output logic memToRegE,
	output logic [1:0] memReadE,
	output logic [3:0] byteEnable,
	output logic [`DATA_W-1:0] storeData
);

	logic isShift; // SLL, SRL or SRA family
	logic fixedShift; // Control-supplied count
	logic [`SHAMT_W-1:0] ctrlShiftAmt;
	logic [`SHAMT_W-1:0] shiftAmount;
	logic [`DATA_W-1:0] srcA;
	logic [`DATA_W-1:0] srcB;
	logic [`DATA_W-1:0] aluOut;
	logic [3:0] laneEnable;
	logic [`DATA_W-1:0] laneData;

	//////////////////////////////
	// Operand select
	//////////////////////////////

	assign isShift = (aluControl == ctrlPkg::ALU_SLL) || (aluControl == ctrlPkg::ALU_SRL)
		|| (aluControl == ctrlPkg::ALU_SRA);
	assign fixedShift = (shift != 4'd0);
	assign ctrlShiftAmt = `SHAMT_W'(shift) << 2; // Nibbles to bits

	always_comb
	begin
		if (fixedShift)
			shiftAmount = ctrlShiftAmt; // LUI
		else if (aluSrc == ctrlPkg::SRC_SHAMT)
			shiftAmount = shamt;
		else
			shiftAmount = rsData[`SHAMT_W-1:0]; // Variable shifts
	end

	assign srcA = !isShift ? rsData : (fixedShift ? immExt : rtData);
	assign srcB = (aluSrc == ctrlPkg::SRC_IMM) ? immExt : rtData;

	aluCore alu
	(
		.aluControl(aluControl),
		.srcA(srcA),
		.srcB(srcB),
		.shiftAmount(shiftAmount),
		.result(aluOut)
	);

	//////////////////////////////
	// Store lanes
	//////////////////////////////

	always_comb
	begin
		case (memWriteSize)
			ctrlPkg::WR_BYTE: laneEnable = 4'b0001 << aluOut[1:0];
			ctrlPkg::WR_HALF: laneEnable = aluOut[1] ? 4'b1100 : 4'b0011;
			ctrlPkg::WR_WORD: laneEnable = 4'b1111;
			default: laneEnable = 4'b0000;
		endcase
		case (memWriteSize)
			ctrlPkg::WR_BYTE: laneData = {(`DATA_W/8){rtData[7:0]}}; // Byte in every lane
			ctrlPkg::WR_HALF: laneData = {(`DATA_W/16){rtData[15:0]}};
			default: laneData = rtData;
		endcase
	end

	//////////////////////////////
	// Pipeline register
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memReadE <= ctrlPkg::RD_WORD;
			byteEnable <= 4'b0000;
		end
		else
		begin
			resultValid <= instrValid;
			regWriteE <= instrValid & regWrite; // Idle cycles write nothing
			memToRegE <= instrValid & memToReg;
			byteEnable <= (instrValid && memWrite) ? laneEnable : 4'b0000;
			if (instrValid)
				memReadE <= memRead;
		end
	end

	// Payload holds its last value between instructions
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			aluResult <= aluOut;
			writeReg <= regDst ? rdIndex : rtIndex;
			storeData <= laneData;
		end
	end

endmodule

/* logic/decodeExecute.sv */
`include "decodeExecute_cfg.svh"

module decodeExecute
(
	input logic clk,
	input logic reset,
	input logic start, // Quiets all controls
	input isaPkg::instrWord instr,
	input logic instrValid,
	input logic [`DATA_W-1:0] rsData, // Already read from the register file
	input logic [`DATA_W-1:0] rtData,
	output logic resultValid,
	output logic [`DATA_W-1:0] aluResult, // Result or memory address
	output logic [`REG_W-1:0] writeReg,
	output logic regWriteE,
	output logic memToRegE,
	output logic [1:0] memReadE,
	output logic [3:0] byteEnable,
	output logic [`DATA_W-1:0] storeData
);

	//////////////////////////////
	// Decode outputs
	//////////////////////////////

	logic [3:0] aluControl;
	logic regWrite;
	logic memToReg;
	logic memWrite;
	logic [1:0] aluSrc;
	logic regDst;
	logic [3:0] shift;
	logic [1:0] memRead;
	logic [1:0] memWriteSize;
	logic [`REG_W-1:0] rtIndex;
	logic [`REG_W-1:0] rdIndex;
	logic [`SHAMT_W-1:0] shamt;
	logic [`DATA_W-1:0] immExt;

	controlUnit control
	(
		.op(instr.r.op),
		.funct(instr.r.funct),
		.start(start),
		.aluControl(aluControl),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.memWrite(memWrite),
		.aluSrc(aluSrc),
		.regDst(regDst),
		.shift(shift),
		.memRead(memRead),
		.memWriteSize(memWriteSize)
	);

	operandUnit operands
	(
		.instr(instr),
		.rtIndex(rtIndex),
		.rdIndex(rdIndex),
		.shamt(shamt),
		.immExt(immExt)
	);

	//////////////////////////////
	// Execute and register
	//////////////////////////////

	executeStage execute
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.rsData(rsData),
		.rtData(rtData),
		.aluControl(aluControl),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.memWrite(memWrite),
		.aluSrc(aluSrc),
		.regDst(regDst),
		.shift(shift),
		.memRead(memRead),
		.memWriteSize(memWriteSize),
		.rtIndex(rtIndex),
		.rdIndex(rdIndex),
		.shamt(shamt),
		.immExt(immExt),
		.resultValid(resultValid),
		.aluResult(aluResult),
		.writeReg(writeReg),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.memReadE(memReadE),
		.byteEnable(byteEnable),
		.storeData(storeData)
	);

endmodule

/* tests/decodeExecuteTb.sv */
`include "decodeExecute_cfg.svh"

module decodeExecuteTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 3;
	localparam int N_IDLE = 8; // Idle cycles after reset
	localparam int N_RTYPE = 200;
	localparam int N_SHIFTIMM = 120;
	localparam int N_MEM = 120;
	localparam int N_QUIET = 60;
	localparam int N_STREAM = 300;
	localparam int CYCLE_LIMIT = N_IDLE + N_RTYPE + N_SHIFTIMM + N_MEM + N_QUIET + N_STREAM + 50;

	localparam logic [5:0] ALU_FUNCTS [7] = '{isaPkg::FN_ADD, isaPkg::FN_SUB, isaPkg::FN_AND,
		isaPkg::FN_OR, isaPkg::FN_XOR, isaPkg::FN_NOR, isaPkg::FN_SLT};
	localparam logic [5:0] SHIFT_FUNCTS [6] = '{isaPkg::FN_SLL, isaPkg::FN_SRL, isaPkg::FN_SRA,
		isaPkg::FN_SLLV, isaPkg::FN_SRLV, isaPkg::FN_SRAV};
	localparam logic [5:0] IMM_OPS [6] = '{isaPkg::OP_ADDI, isaPkg::OP_ANDI, isaPkg::OP_ORI,
		isaPkg::OP_XORI, isaPkg::OP_SLTI, isaPkg::OP_LUI};
	localparam logic [5:0] MEM_OPS [9] = '{isaPkg::OP_LB, isaPkg::OP_LH, isaPkg::OP_LW,
		isaPkg::OP_LBU, isaPkg::OP_LHU, isaPkg::OP_LWU, isaPkg::OP_SB, isaPkg::OP_SH, isaPkg::OP_SW};
	localparam logic [5:0] BAD_OPS [5] = '{6'h02, 6'h04, 6'h10, 6'h22, 6'h30}; // Outside the ISA

	logic clk = 1'b0;
	logic reset;
	logic start;
	isaPkg::instrWord instr;
	logic instrValid;
	logic [`DATA_W-1:0] rsData;
	logic [`DATA_W-1:0] rtData;
	logic resultValid;
	logic [`DATA_W-1:0] aluResult;
	logic [`REG_W-1:0] writeReg;
	logic regWriteE;
	logic memToRegE;
	logic [1:0] memReadE;
	logic [3:0] byteEnable;
	logic [`DATA_W-1:0] storeData;

	logic armed = 1'b0; // First edge has nothing to compare
	logic expValid = 1'b0; // Expected for the instruction sampled one edge ago
	logic [`DATA_W-1:0] expResult;
	logic [`REG_W-1:0] expWriteReg;
	logic expRegWrite = 1'b0;
	logic expMemToReg = 1'b0;
	logic [1:0] expMemRead;
	logic [3:0] expByteEn = 4'b0000;
	logic [`DATA_W-1:0] expStoreData;
	int errorCount = 0;
	int checkCount = 0;
	int instrCount = 0;
	int cycleCount = 0;
	int testCount = 0;
	int errorsBefore = 0;

	decodeExecute UUT
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.instr(instr),
		.instrValid(instrValid),
		.rsData(rsData),
		.rtData(rtData),
		.resultValid(resultValid),
		.aluResult(aluResult),
		.writeReg(writeReg),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.memReadE(memReadE),
		.byteEnable(byteEnable),
		.storeData(storeData)
	);

	always #50 clk = ~clk; // 100 ns period

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic void refModel(
		input logic [31:0] ins,
		input logic st,
		input logic [`DATA_W-1:0] rs,
		input logic [`DATA_W-1:0] rt,
		output logic [`DATA_W-1:0] res,
		output logic [`REG_W-1:0] wrReg,
		output logic regWr,
		output logic memToReg,
		output logic [1:0] memRd,
		output logic [3:0] byteEn,
		output logic [`DATA_W-1:0] stData
	);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] sa;
		logic [31:0] imm;
		logic [1:0] wrSize;
		op = ins[31:26];
		fn = ins[5:0];
		sa = ins[10:6];
		imm = {{16{ins[15]}}, ins[15:0]}; // Sign-extended unless logical
		if (op == isaPkg::OP_ANDI || op == isaPkg::OP_ORI || op == isaPkg::OP_XORI)
			imm = {16'h0000, ins[15:0]};
		res = rs + rt; // Quiet controls mean ADD of both registers
		wrReg = ins[20:16]; // rt unless regDst
		regWr = 1'b0;
		memToReg = 1'b0;
		memRd = ctrlPkg::RD_WORD;
		wrSize = ctrlPkg::WR_NONE;
		if (!st)
		begin
			case (op)
				isaPkg::OP_RTYPE:
				begin
					regWr = 1'b1;
					wrReg = ins[15:11];
					case (fn)
						isaPkg::FN_ADD: res = rs + rt;
						isaPkg::FN_SUB: res = rs - rt;
						isaPkg::FN_AND: res = rs & rt;
						isaPkg::FN_OR: res = rs | rt;
						isaPkg::FN_XOR: res = rs ^ rt;
						isaPkg::FN_NOR: res = ~(rs | rt);
						isaPkg::FN_SLT: res = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
						isaPkg::FN_SLL: res = rt << sa;
						isaPkg::FN_SRL: res = rt >> sa;
						isaPkg::FN_SRA: res = $signed(rt) >>> sa;
						isaPkg::FN_SLLV: res = rt << rs[4:0]; // Count from rs
						isaPkg::FN_SRLV: res = rt >> rs[4:0];
						isaPkg::FN_SRAV: res = $signed(rt) >>> rs[4:0];
						default:
						begin
							regWr = 1'b0; // Unknown funct stays quiet
							wrReg = ins[20:16];
						end
					endcase
				end
				isaPkg::OP_LB, isaPkg::OP_LBU, isaPkg::OP_LH, isaPkg::OP_LHU, isaPkg::OP_LW,
				isaPkg::OP_LWU:
				begin
					res = rs + imm; // Address
					regWr = 1'b1;
					memToReg = 1'b1;
					if (op == isaPkg::OP_LB || op == isaPkg::OP_LBU)
						memRd = ctrlPkg::RD_BYTE;
					else if (op == isaPkg::OP_LH || op == isaPkg::OP_LHU)
						memRd = ctrlPkg::RD_HALF;
				end
				isaPkg::OP_SB, isaPkg::OP_SH, isaPkg::OP_SW:
				begin
					res = rs + imm;
					if (op == isaPkg::OP_SB)
						wrSize = ctrlPkg::WR_BYTE;
					else if (op == isaPkg::OP_SH)
						wrSize = ctrlPkg::WR_HALF;
					else
						wrSize = ctrlPkg::WR_WORD;
				end
				isaPkg::OP_ADDI, isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI, isaPkg::OP_SLTI,
				isaPkg::OP_LUI:
				begin
					regWr = 1'b1;
					case (op)
						isaPkg::OP_ANDI: res = rs & imm;
						isaPkg::OP_ORI: res = rs | imm;
						isaPkg::OP_XORI: res = rs ^ imm;
						isaPkg::OP_SLTI: res = ($signed(rs) < $signed(imm)) ? 32'd1 : 32'd0;
						isaPkg::OP_LUI: res = {ins[15:0], 16'h0000}; // Upper half load
						default: res = rs + imm; // ADDI
					endcase
				end
				default: regWr = 1'b0; // END and unknown opcodes
			endcase
		end
		case (wrSize)
			ctrlPkg::WR_BYTE: byteEn = 4'b0001 << res[1:0];
			ctrlPkg::WR_HALF: byteEn = res[1] ? 4'b1100 : 4'b0011;
			ctrlPkg::WR_WORD: byteEn = 4'b1111;
			default: byteEn = 4'b0000;
		endcase
		case (wrSize)
			ctrlPkg::WR_BYTE: stData = {4{rt[7:0]}}; // Byte in all lanes
			ctrlPkg::WR_HALF: stData = {2{rt[15:0]}};
			default: stData = rt;
		endcase
	endfunction

	//////////////////////////////
	// Instruction generators
	//////////////////////////////

	function automatic logic [31:0] rType(input logic [5:0] fn);
		logic [31:0] r;
		r = $urandom;
		return {isaPkg::OP_RTYPE, r[25:6], fn}; // Random rs, rt, rd, shamt
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op);
		logic [31:0] r;
		r = $urandom;
		return {op, r[25:0]};
	endfunction

	// Group 0 R-type ALU, 1 shift or immediate, 2 load or store
	function automatic logic [31:0] supportedInstr(input int group);
		int idx;
		idx = $urandom % 12;
		if (group == 0)
			return rType(ALU_FUNCTS[idx % 7]);
		else if (group == 1 && idx < 6)
			return rType(SHIFT_FUNCTS[idx]);
		else if (group == 1)
			return iType(IMM_OPS[idx - 6]);
		else
			return iType(MEM_OPS[idx % 9]);
	endfunction

	function automatic logic [31:0] quietInstr();
		int idx;
		idx = $urandom % 3;
		if (idx == 0)
			return iType(isaPkg::OP_END);
		else if (idx == 1)
			return iType(BAD_OPS[$urandom % 5]);
		else
			return rType(6'h01); // Funct outside the ISA
	endfunction

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic issue(input logic [31:0] word, input logic quiet);
		@(negedge clk);
		instr = word;
		start = quiet;
		instrValid = 1'b1;
		rsData = $urandom;
		rtData = $urandom;
		instrCount++;
	endtask

	task automatic finishTest(input string name);
		@(negedge clk);
		instrValid = 1'b0; // Last result still in flight
		start = 1'b0;
		@(negedge clk);
		testCount++;
		$display("Test %0d %s finished with %0d errors", testCount, name,
			errorCount - errorsBefore);
		errorsBefore = errorCount;
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errorCount++;
		$display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
	endtask

	//////////////////////////////
	// Comparison
	//////////////////////////////

	// Outputs read here still hold the previous edge's values
	always @(posedge clk)
	begin
		if (armed)
		begin
			checkCount++;
			if (expValid && resultValid !== 1'b1)
			begin
				errorCount++;
				$display("At %0t no resultValid pulse came for an issued instruction", $time);
			end
			if (!expValid && resultValid !== 1'b0)
			begin
				errorCount++;
				$display("At %0t resultValid pulsed with no instruction issued", $time);
			end
			if (regWriteE !== expRegWrite)
				reportMismatch("regWriteE", 32'(expRegWrite), 32'(regWriteE));
			if (memToRegE !== expMemToReg)
				reportMismatch("memToRegE", 32'(expMemToReg), 32'(memToRegE));
			if (byteEnable !== expByteEn)
				reportMismatch("byteEnable", 32'(expByteEn), 32'(byteEnable));
			if (expValid && aluResult !== expResult)
				reportMismatch("aluResult", expResult, aluResult);
			if (expValid && writeReg !== expWriteReg)
				reportMismatch("writeReg", 32'(expWriteReg), 32'(writeReg));
			if (expValid && memReadE !== expMemRead)
				reportMismatch("memReadE", 32'(expMemRead), 32'(memReadE));
			if (expValid && storeData !== expStoreData)
				reportMismatch("storeData", expStoreData, storeData);
		end
		expValid = !reset && instrValid;
		if (expValid)
			refModel(instr, start, rsData, rtData, expResult, expWriteReg, expRegWrite,
				expMemToReg, expMemRead, expByteEn, expStoreData);
		else
		begin
			expRegWrite = 1'b0; // Idle or reset
			expMemToReg = 1'b0;
			expByteEn = 4'b0000;
		end
		armed = 1'b1;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > CYCLE_LIMIT)
		begin
			$display("Run stopped after %0d cycles before the tests completed", cycleCount);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		int pick;
		void'($urandom(32'hc116_836c)); // One seed for the run
		reset = 1'b1;
		start = 1'b0;
		instr = '0;
		instrValid = 1'b1; // Reset overrides valid instructions
		rsData = '0;
		rtData = '0;
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			instr = iType((i % 2 == 0) ? isaPkg::OP_LW : isaPkg::OP_SW);
			@(negedge clk);
		end
		reset = 1'b0;
		instrValid = 1'b0;
		for (int i = 0; i < N_IDLE; i++)
		begin
			instr = iType(MEM_OPS[i % 9]); // Loads and stores left on the bus
			rsData = $urandom;
			rtData = $urandom;
			@(negedge clk);
		end
		finishTest("reset and idle");
		for (int i = 0; i < N_RTYPE; i++)
			issue(supportedInstr(0), 1'b0);
		finishTest("R-type ALU");
		for (int i = 0; i < N_SHIFTIMM; i++)
			issue(supportedInstr(1), 1'b0);
		finishTest("shifts and immediates");
		for (int i = 0; i < N_MEM; i++)
			issue(supportedInstr(2), 1'b0);
		finishTest("loads and stores");
		for (int i = 0; i < N_QUIET; i++)
		begin
			if (i % 2 == 0)
				issue(supportedInstr(i % 3), 1'b1); // Held quiet by start
			else
				issue(quietInstr(), 1'b0);
		end
		finishTest("control quieting");
		for (int i = 0; i < N_STREAM; i++)
		begin
			pick = $urandom % 8;
			if (pick < 6)
				issue(supportedInstr(pick % 3), 1'b0);
			else if (pick == 6)
				issue(supportedInstr(i % 3), 1'b1);
			else
				issue(quietInstr(), 1'b0);
		end
		finishTest("back-to-back stream");
		$display("Summary %0d tests, %0d instructions, %0d cycles checked, %0d errors",
			testCount, instrCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* decodeExecute.f */
+incdir+logic
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/controlUnit.sv
logic/operandUnit.sv
logic/aluCore.sv
logic/executeStage.sv
logic/decodeExecute.sv
tests/decodeExecuteTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -f decodeExecute.f --top-module decodeExecuteTb -o decodeExecuteSim
./obj_dir/decodeExecuteSim > sim.log 2>&1
cat sim.log
if grep -q "^Test passed$" sim.log
then
	echo "Simulation result: PASS"
	exit 0
else
	echo "Simulation result: FAIL"
	exit 1
fi
